// File: src/synth_pkg.sv
package synth_pkg;

	// voice and oscillator geometry
	localparam int V_OSC   = 4;	// one 16-address block per osc
	localparam int V_WIDTH = 3;
	localparam int O_WIDTH = 2;

	// datapath widths
	localparam int LS_W   = 25;	// level x sine
	localparam int LVL_W  = 32;	// after osc level
	localparam int PROD_W = 41;	// after pan factor
	localparam int ACC_W  = 64;

	// parameter bus address map
	localparam logic [3:0] ADR_OSC_LVL = 4'd2;	// offset inside osc block
	localparam logic [3:0] ADR_OSC_PAN = 4'd7;
	localparam logic [6:0] ADR_M_VOL   = 7'd1;	// common space

	// one slot of the envelope/sine engine
	typedef struct packed {
		logic [V_WIDTH-1:0] voice;
		logic [O_WIDTH-1:0] osc;
	} slot_t;

	// programmed values of a single oscillator
	typedef struct packed {
		logic signed [7:0] lvl;
		logic signed [7:0] pan;
	} osc_param_t;

	// panned products of one slot, tagged with that slot
	typedef struct packed {
		logic signed [PROD_W-1:0] left;
		logic signed [PROD_W-1:0] right;
		slot_t                    tag;
	} mix_prod_t;

endpackage

// File: src/param_regs.sv
module param_regs import synth_pkg::*; (
	input  logic                           sCLK_XVXENVS,
	input  logic                           reset_data_N,
	input  logic [6:0]                     adr,
	input  logic [7:0]                     wdata,
	input  logic                           write,
	input  logic                           read,
	input  logic                           osc_sel,
	input  logic                           com_sel,
	output logic [7:0]                     rdata,
	output osc_param_t [V_OSC-1:0]         osc_params,
	output logic signed [7:0]              m_vol
);

	logic               osc_hit;	// address lands in the osc space
	logic [O_WIDTH-1:0] osc_idx;
	logic [3:0]         osc_offs;
	logic               com_hit;
	logic [7:0]         rd_val;

	// osc blocks sit at 16-address strides, upper half of adr unmapped
	assign osc_hit  = osc_sel && (adr[6] == 1'b0);
	assign osc_idx  = adr[5:4];
	assign osc_offs = adr[3:0];
	assign com_hit  = com_sel && (adr == ADR_M_VOL);

	// register file with reset defaults
	always_ff @(posedge sCLK_XVXENVS) begin
		if (!reset_data_N) begin
			for (int i = 0; i < V_OSC; i++) begin
				osc_params[i].lvl <= (i <= 1) ? 8'sh40 : 8'sh00;	// only osc 0 and 1 audible
				osc_params[i].pan <= 8'sh40;	// centre
			end
			m_vol <= 8'sh40;
		end else if (write) begin
			if (osc_hit) begin
				case (osc_offs)
					ADR_OSC_LVL: osc_params[osc_idx].lvl <= wdata;
					ADR_OSC_PAN: osc_params[osc_idx].pan <= wdata;
					default: ;
				endcase
			end else if (com_hit) begin
				m_vol <= wdata;
			end
		end
	end

	// read mux, anything not mapped gives 0
	always_comb begin
		rd_val = 8'h00;
		if (osc_hit) begin
			case (osc_offs)
				ADR_OSC_LVL: rd_val = osc_params[osc_idx].lvl;
				ADR_OSC_PAN: rd_val = osc_params[osc_idx].pan;
				default:     rd_val = 8'h00;
			endcase
		end else if (com_hit) begin
			rd_val = m_vol;
		end
	end

	// rdata holds until the next read pulse
	always_ff @(posedge sCLK_XVXENVS) begin
		if (!reset_data_N) begin
			rdata <= 8'h00;
		end else if (read) begin
			rdata <= rd_val;
		end
	end

	// the bus master never selects both spaces for one access
	a_one_select: assert property (
		@(posedge sCLK_XVXENVS) disable iff (!reset_data_N)
		(write || read) |-> !(osc_sel && com_sel)
	) else $error("osc_sel and com_sel both high during a bus access");

endmodule

// File: src/osc_mix_pipe.sv
module osc_mix_pipe import synth_pkg::*; #(
	parameter int VOICES = 8
) (
	input  logic                     sCLK_XVXENVS,
	input  logic                     reset_data_N,
	input  slot_t                    slot,
	input  logic signed [7:0]        level,
	input  logic signed [16:0]       sine,
	input  osc_param_t [V_OSC-1:0]   osc_params,
	output mix_prod_t                prod
);

	// stage 1
	slot_t                   s1_tag;
	logic signed [LS_W-1:0]  s1_ls;	// level x sine

	// stage 2
	slot_t                   s2_tag;
	logic signed [LVL_W-1:0] s2_mix;
	logic signed [7:0]       s2_pan;	// pan sampled with lvl

	// pan factors, 127 - pan needs the ninth bit
	logic signed [8:0] pan_r;
	logic signed [8:0] pan_l;

	assign pan_r = s2_pan;
	assign pan_l = 9'sd127 - pan_r;

	always_ff @(posedge sCLK_XVXENVS) begin
		if (!reset_data_N) begin
			s1_tag     <= '0;
			s1_ls      <= '0;
			s2_tag     <= '0;
			s2_mix     <= '0;
			s2_pan     <= '0;
			prod       <= '0;	// tag 0 keeps the frame end detector quiet
		end else begin
			s1_tag <= slot;
			s1_ls  <= level * sine;

			// osc params are read here, for the slot now in stage 2
			s2_tag <= s1_tag;
			s2_mix <= s1_ls * osc_params[s1_tag.osc].lvl;
			s2_pan <= osc_params[s1_tag.osc].pan;

			prod.tag   <= s2_tag;
			prod.left  <= s2_mix * pan_l;
			prod.right <= s2_mix * pan_r;
		end
	end

	// engine only visits configured voices
	a_voice_range: assert property (
		@(posedge sCLK_XVXENVS) disable iff (!reset_data_N)
		int'(slot.voice) < VOICES
	) else $error("slot voice %0d out of range", slot.voice);

endmodule

// File: src/voice_mix_out.sv
module voice_mix_out import synth_pkg::*; #(
	parameter int VOICES    = 8,
	parameter int OUT_SHIFT = 34
) (
	input  logic                sCLK_XVXENVS,
	input  logic                reset_data_N,
	input  mix_prod_t           prod,
	input  logic signed [7:0]   m_vol,
	output logic signed [15:0]  lsound_out,
	output logic signed [15:0]  rsound_out,
	output logic                sample_strobe
);

	logic signed [ACC_W-1:0] acc_l;
	logic signed [ACC_W-1:0] acc_r;
	logic signed [ACC_W-1:0] sum_l;	// running sum incl. current prod
	logic signed [ACC_W-1:0] sum_r;
	logic signed [ACC_W-1:0] full_l;
	logic signed [ACC_W-1:0] full_r;
	logic                    frame_end;

	assign frame_end = (prod.tag.voice == V_WIDTH'(VOICES - 1)) &&
		(prod.tag.osc == O_WIDTH'(V_OSC - 1));

	assign sum_l  = acc_l + prod.left;
	assign sum_r  = acc_r + prod.right;
	assign full_l = (sum_l * m_vol) >>> OUT_SHIFT;	// master volume then scale down
	assign full_r = (sum_r * m_vol) >>> OUT_SHIFT;

	always_ff @(posedge sCLK_XVXENVS) begin
		if (!reset_data_N) begin
			acc_l         <= '0;
			acc_r         <= '0;
			lsound_out    <= '0;
			rsound_out    <= '0;
			sample_strobe <= 1'b0;
		end else if (frame_end) begin
			lsound_out    <= full_l[15:0];
			rsound_out    <= full_r[15:0];
			sample_strobe <= 1'b1;
			acc_l         <= '0;	// next frame starts clean
			acc_r         <= '0;
		end else begin
			acc_l         <= sum_l;
			acc_r         <= sum_r;
			sample_strobe <= 1'b0;
		end
	end

	// one strobe per frame, frames are always longer than one slot
	a_strobe_pulse: assert property (
		@(posedge sCLK_XVXENVS) disable iff (!reset_data_N)
		sample_strobe |=> !sample_strobe
	) else $error("sample_strobe high on consecutive cycles");

endmodule

// File: src/mixer_top.sv
module mixer_top import synth_pkg::*; #(
	parameter int VOICES    = 8,
	parameter int OUT_SHIFT = 34
) (
	input  logic                sCLK_XVXENVS,
	input  logic                reset_data_N,
	// slot stream from the envelope/sine engine
	input  slot_t               slot,
	input  logic signed [7:0]   level,
	input  logic signed [16:0]  sine,
	// parameter bus
	input  logic [6:0]          adr,
	input  logic [7:0]          wdata,
	input  logic                write,
	input  logic                read,
	input  logic                osc_sel,
	input  logic                com_sel,
	output logic [7:0]          rdata,
	// stereo sample
	output logic signed [15:0]  lsound_out,
	output logic signed [15:0]  rsound_out,
	output logic                sample_strobe
);

	osc_param_t [V_OSC-1:0] osc_params;
	logic signed [7:0]      m_vol;
	mix_prod_t              prod;

	param_regs i_regs (
		.sCLK_XVXENVS (sCLK_XVXENVS),
		.reset_data_N (reset_data_N),
		.adr          (adr),
		.wdata        (wdata),
		.write        (write),
		.read         (read),
		.osc_sel      (osc_sel),
		.com_sel      (com_sel),
		.rdata        (rdata),
		.osc_params   (osc_params),
		.m_vol        (m_vol)
	);

	// 3 cycles slot to prod
	osc_mix_pipe #(.VOICES(VOICES)) i_pipe (
		.sCLK_XVXENVS (sCLK_XVXENVS),
		.reset_data_N (reset_data_N),
		.slot         (slot),
		.level        (level),
		.sine         (sine),
		.osc_params   (osc_params),
		.prod         (prod)
	);

	// one more cycle to the strobed sample
	voice_mix_out #(.VOICES(VOICES), .OUT_SHIFT(OUT_SHIFT)) i_out (
		.sCLK_XVXENVS  (sCLK_XVXENVS),
		.reset_data_N  (reset_data_N),
		.prod          (prod),
		.m_vol         (m_vol),
		.lsound_out    (lsound_out),
		.rsound_out    (rsound_out),
		.sample_strobe (sample_strobe)
	);

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic sCLK_XVXENVS,
	output logic reset_data_N
);

	initial begin
		sCLK_XVXENVS = 1'b0;
		forever #(PERIOD / 2) sCLK_XVXENVS = ~sCLK_XVXENVS;
	end

	// release on a falling edge, away from the DUT's sampling edge
	initial begin
		reset_data_N = 1'b0;
		repeat (RESET_CYCLES) @(posedge sCLK_XVXENVS);
		@(negedge sCLK_XVXENVS);
		reset_data_N = 1'b1;
	end

endmodule

// File: verif/tb_mixer.sv
module tb_mixer import synth_pkg::*; ();

	localparam int VOICES          = 8;
	localparam int OUT_SHIFT       = 34;
	localparam int PERIOD          = 20;
	localparam int SLOTS           = VOICES * V_OSC;	// slots per frame
	localparam int N_FRAMES        = 40;	// upper bound over all scenarios
	localparam int N_ACCESS        = 80;	// bus accesses, two cycles each
	localparam int WATCHDOG_CYCLES = N_FRAMES * SLOTS + N_ACCESS * 2 + 100;
	localparam logic [31:0] RAND_SEED = 32'h40f0a2ab;

	logic               sCLK_XVXENVS;
	logic               reset_data_N;
	slot_t              slot;
	logic signed [7:0]  level;
	logic signed [16:0] sine;
	logic [6:0]         adr;
	logic [7:0]         wdata;
	logic               write;
	logic               read;
	logic               osc_sel;
	logic               com_sel;
	logic [7:0]         rdata;
	logic signed [15:0] lsound_out;
	logic signed [15:0] rsound_out;
	logic               sample_strobe;

	// reference copy of the register bank
	logic signed [7:0] ref_lvl [V_OSC];
	logic signed [7:0] ref_pan [V_OSC];
	logic signed [7:0] ref_vol;

	int     slot_cnt;
	longint frame_l;
	longint frame_r;
	longint pend_l;	// finished frame waiting for its strobe
	longint pend_r;
	bit     frame_dirty;
	bit     pend_dirty;
	bit [3:0] last_hist;	// last-slot flags of the previous 4 cycles
	int     strobes_seen;
	bit     silent_l;
	bit     silent_r;

	tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(4)) i_clk (
		.sCLK_XVXENVS (sCLK_XVXENVS),
		.reset_data_N (reset_data_N)
	);

	mixer_top #(.VOICES(VOICES), .OUT_SHIFT(OUT_SHIFT)) i_dut (.*);

	task automatic report_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("FAIL at %0t: %s expected %0h, got %0h", $time, name, exp, act);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		assert (exp === act) else report_value(name, exp, act);
	endtask

	// nothing strobes or reads back while reset is held
	a_reset_strobe: assert property (
		@(posedge sCLK_XVXENVS) !reset_data_N |=> !sample_strobe
	) else report_value("sample_strobe", 0, 64'($sampled(sample_strobe)));

	a_reset_rdata: assert property (
		@(posedge sCLK_XVXENVS) !reset_data_N |=> rdata == 8'h00
	) else report_value("rdata", 0, 64'($sampled(rdata)));

	function automatic logic [6:0] osc_adr(input int o, input int offs);
		return 7'(o * 16 + offs);	// 16 addresses per osc
	endfunction

	task automatic model_reset();
		for (int k = 0; k < V_OSC; k++) begin
			ref_lvl[k] = (k < 2) ? 8'sh40 : 8'sh00;
			ref_pan[k] = 8'sh40;
		end
		ref_vol = 8'sh40;
	endtask

	function automatic logic [7:0] expected_read(input bit com, input logic [6:0] a);
		if (com)
			return (a == 7'd1) ? ref_vol : 8'h00;	// master volume at 1
		if (a[6])
			return 8'h00;
		if (a[3:0] == 4'd2)
			return ref_lvl[a[5:4]];
		if (a[3:0] == 4'd7)
			return ref_pan[a[5:4]];
		return 8'h00;
	endfunction

	task automatic model_write(input bit com, input logic [6:0] a, input logic [7:0] d);
		if (com) begin
			if (a == 7'd1)
				ref_vol = d;
		end else if (!a[6]) begin
			if (a[3:0] == 4'd2)
				ref_lvl[a[5:4]] = d;
			else if (a[3:0] == 4'd7)
				ref_pan[a[5:4]] = d;
		end
	endtask

	function automatic logic [15:0] scale_out(input longint sum);
		longint scaled;
		scaled = (sum * longint'(ref_vol)) >>> OUT_SHIFT;
		return scaled[15:0];
	endfunction

	// one clock: check outputs, then drive the next slot
	task automatic tick();
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		longint      ls;
		int          o;
		@(negedge sCLK_XVXENVS);
		check_equal("sample_strobe", 64'(last_hist[3]), 64'(sample_strobe));
		if (last_hist[3]) begin
			strobes_seen++;
			exp_l = scale_out(pend_l);
			exp_r = scale_out(pend_r);
			if (!pend_dirty) begin
				check_equal("lsound_out", exp_l, $unsigned(lsound_out));
				check_equal("rsound_out", exp_r, $unsigned(rsound_out));
			end
			if (silent_l)
				check_equal("lsound_out", 0, $unsigned(lsound_out));
			if (silent_r)
				check_equal("rsound_out", 0, $unsigned(rsound_out));
		end
		o = slot_cnt % V_OSC;
		slot.voice = V_WIDTH'(slot_cnt / V_OSC);
		slot.osc   = O_WIDTH'(o);
		level      = 8'($urandom);
		sine       = 17'($urandom);
		ls = longint'(level) * longint'(sine) * longint'(ref_lvl[o]);
		frame_l += ls * (127 - longint'(ref_pan[o]));
		frame_r += ls * longint'(ref_pan[o]);
		last_hist = {last_hist[2:0], slot_cnt == SLOTS - 1};
		if (slot_cnt == SLOTS - 1) begin
			pend_l      = frame_l;
			pend_r      = frame_r;
			pend_dirty  = frame_dirty;
			frame_l     = 0;
			frame_r     = 0;
			frame_dirty = 1'b0;
			slot_cnt    = 0;
		end else begin
			slot_cnt++;
		end
	endtask

	task automatic bus_write(input bit com, input logic [6:0] a, input logic [7:0] d);
		tick();
		adr     = a;
		wdata   = d;
		write   = 1'b1;
		osc_sel = !com;
		com_sel = com;
		model_write(com, a, d);
		frame_dirty = 1'b1;	// mix changes mid frame
		pend_dirty  = 1'b1;
		tick();
		write   = 1'b0;
		osc_sel = 1'b0;
		com_sel = 1'b0;
	endtask

	task automatic bus_read(input bit com, input logic [6:0] a);
		tick();
		adr     = a;
		read    = 1'b1;
		osc_sel = !com;
		com_sel = com;
		tick();
		read    = 1'b0;
		osc_sel = 1'b0;
		com_sel = 1'b0;
		check_equal("rdata", expected_read(com, a), rdata);	// valid one cycle after pulse
	endtask

	task automatic run_frames(input int n);
		int target;
		target = strobes_seen + n;
		while (strobes_seen < target)
			tick();
	endtask

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("timeout: the test did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$fatal(1);
	end

	initial begin
		int         pick;
		int         k;
		bit         com;
		logic [6:0] a;
		logic [7:0] d;
		void'($urandom(RAND_SEED));
		slot    = '0;
		level   = '0;
		sine    = '0;
		adr     = '0;
		wdata   = '0;
		write   = 1'b0;
		read    = 1'b0;
		osc_sel = 1'b0;
		com_sel = 1'b0;
		slot_cnt     = 0;
		frame_l      = 0;
		frame_r      = 0;
		pend_l       = 0;
		pend_r       = 0;
		frame_dirty  = 1'b0;
		pend_dirty   = 1'b0;
		last_hist    = '0;
		strobes_seen = 0;
		silent_l     = 1'b0;
		silent_r     = 1'b0;
		model_reset();
		@(posedge reset_data_N);
		check_equal("rdata", 0, rdata);
		check_equal("lsound_out", 0, $unsigned(lsound_out));
		check_equal("rsound_out", 0, $unsigned(rsound_out));
		check_equal("sample_strobe", 0, sample_strobe);

		// defaults and unmapped holes
		for (int o = 0; o < V_OSC; o++) begin
			bus_read(1'b0, osc_adr(o, 2));
			bus_read(1'b0, osc_adr(o, 7));
			bus_read(1'b0, osc_adr(o, 3));
		end
		bus_read(1'b1, 7'd1);
		bus_read(1'b1, 7'd0);
		bus_read(1'b0, 7'h42);	// upper half of osc space

		repeat (12) begin
			pick = $urandom_range(0, 2);
			k    = $urandom_range(0, V_OSC - 1);
			com  = (pick == 2);
			a    = com ? 7'd1 : osc_adr(k, (pick == 0) ? 2 : 7);
			d    = 8'($urandom);
			bus_write(com, a, d);
			bus_read(com, a);
		end
		bus_write(1'b1, 7'd1, 8'h7f);
		run_frames(2);
		run_frames(6);

		// only osc 1 audible, hard left then hard right
		for (int o = 0; o < V_OSC; o++)
			bus_write(1'b0, osc_adr(o, 2), (o == 1) ? 8'h5a : 8'h00);
		bus_write(1'b0, osc_adr(1, 7), 8'h00);
		run_frames(2);
		silent_r = 1'b1;
		run_frames(3);
		silent_r = 1'b0;
		bus_write(1'b0, osc_adr(1, 7), 8'h7f);
		run_frames(2);
		silent_l = 1'b1;
		run_frames(3);
		silent_l = 1'b0;

		// master volume muted
		bus_write(1'b0, osc_adr(0, 2), 8'h40);
		bus_write(1'b1, 7'd1, 8'h00);
		run_frames(2);
		silent_l = 1'b1;
		silent_r = 1'b1;
		run_frames(3);

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: sim.f
src/synth_pkg.sv
src/param_regs.sv
src/osc_mix_pipe.sv
src/voice_mix_out.sv
src/mixer_top.sv
verif/tb_clock_gen.sv
verif/tb_mixer.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mixer
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
